//--- src/common_pkg.sv
// ****************************************
// Common bus types
// Widths and vector types of the CPU and host buses
// ****************************************

package common_pkg;

    // CPU bus widths
    localparam int DATA_WIDTH = 8;   // 6502 data bus
    localparam int ADDR_WIDTH = 16;  // 6502 address bus

    // Host register target width
    localparam int HOST_ADDR_WIDTH = 5;  // Key rows 0..9, config at 16

    // Bus data, key rows and register values
    typedef logic [DATA_WIDTH-1:0] data_t;

    // Full CPU address
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // Target of a host register write
    typedef logic [HOST_ADDR_WIDTH-1:0] host_addr_t;

endpackage : common_pkg

//--- src/io_map_pkg.sv
// ****************************************
// I/O memory map
// Addresses, offsets, mux positions and config bits
// ****************************************

package io_map_pkg;

    import common_pkg::*;

    // Offset within the I/O page
    localparam int IO_OFS_BITS = 8;
    typedef logic [IO_OFS_BITS-1:0] io_ofs_t;

    // CPU address map
    localparam addr_t   IO_BASE     = 16'hE800;  // I/O page, E800..E8FF
    localparam io_ofs_t KBD_ROW_OFS = 8'h10;     // Row select, read/write
    localparam io_ofs_t KBD_COL_OFS = 8'h12;     // Column read, active low
    localparam io_ofs_t CFG_OFS     = 8'hF0;     // Config register
    localparam addr_t   ROM_BASE    = 16'h9000;  // ROM images in SRAM from here up

    // Positions of the FPGA read sources on the data mux
    localparam int SRC_KBD_ROW = 0;
    localparam int SRC_KBD_COL = 1;
    localparam int SRC_CFG     = 2;
    localparam int SRC_COUNT   = 3;

    // Config register layout
    localparam int CFG_ROM_WE_BIT = 0;  // Allow SRAM writes at and above ROM_BASE
    localparam int CFG_KBD_EN_BIT = 1;  // Clear forces column reads to all ones
    localparam int CFG_BITS       = 2;
    localparam logic [CFG_BITS-1:0] CFG_RESET = 2'b10;  // Keyboard on, ROM locked

    // Keyboard matrix size and host config target
    localparam int         KEY_ROWS      = 10;
    localparam host_addr_t HOST_CFG_ADDR = 5'd16;

endpackage : io_map_pkg

//--- src/address_decoder.sv
// ****************************************
// Address decoder
// Turns a CPU bus cycle into SRAM controls and FPGA selects
// ****************************************

`timescale 1ns/1ps

module address_decoder
    import common_pkg::*;
    import io_map_pkg::*;
(
    // CPU bus cycle
    input  logic                 cpu_strobe_i,  // One clock per bus cycle
    input  logic                 cpu_rw_i,      // 1 = read
    input  addr_t                cpu_addr_i,

    // Config
    input  logic                 rom_we_en_i,   // ROM area writable

    // FPGA selects
    output logic [SRC_COUNT-1:0] src_oe_o,      // One-hot read source
    output logic                 row_we_o,      // Row select write
    output logic                 cfg_we_o,      // Config write

    // SRAM controls
    output logic                 ram_oe_o,
    output logic                 ram_we_o
);
    logic    rd_cycle;   // Read strobe
    logic    wr_cycle;   // Write strobe
    logic    io_hit;     // Address in the I/O page
    logic    rom_area;   // Address at or above ROM_BASE
    io_ofs_t io_ofs;     // Offset within the I/O page

    assign rd_cycle = cpu_strobe_i &  cpu_rw_i;
    assign wr_cycle = cpu_strobe_i & ~cpu_rw_i;

    // Page compare on the upper address bits
    assign io_hit   = (cpu_addr_i[ADDR_WIDTH-1:IO_OFS_BITS] ==
                       IO_BASE[ADDR_WIDTH-1:IO_OFS_BITS]);
    assign io_ofs   = cpu_addr_i[IO_OFS_BITS-1:0];
    assign rom_area = (cpu_addr_i >= ROM_BASE);

    // FPGA read sources, at most one bit set
    always_comb begin
        src_oe_o              = '0;
        src_oe_o[SRC_KBD_ROW] = rd_cycle & io_hit & (io_ofs == KBD_ROW_OFS);
        src_oe_o[SRC_KBD_COL] = rd_cycle & io_hit & (io_ofs == KBD_COL_OFS);
        src_oe_o[SRC_CFG]     = rd_cycle & io_hit & (io_ofs == CFG_OFS);
    end

    // Register writes; the column register is read only
    assign row_we_o = wr_cycle & io_hit & (io_ofs == KBD_ROW_OFS);
    assign cfg_we_o = wr_cycle & io_hit & (io_ofs == CFG_OFS);

    // Everything outside the I/O page belongs to SRAM
    assign ram_oe_o = rd_cycle & ~io_hit;
    assign ram_we_o = wr_cycle & ~io_hit & (~rom_area | rom_we_en_i);  // ROM write guard

endmodule : address_decoder

//--- src/keyboard_matrix.sv
// ****************************************
// Keyboard matrix
// Host-loaded key rows scanned through row and column registers
// ****************************************

`timescale 1ns/1ps

module keyboard_matrix
    import common_pkg::*;
#(
    parameter int ROWS = 10  // Rows in the matrix
) (
    input  logic       clk_i,
    input  logic       rst_n_i,

    // CPU row select write
    input  logic       row_we_i,
    input  data_t      cpu_wdata_i,

    // Host key row write
    input  logic       key_we_i,
    input  host_addr_t key_row_i,
    input  data_t      key_data_i,   // 1 = key pressed

    // Scan enable from config
    input  logic       kbd_en_i,

    // CPU read sources
    output data_t      row_sel_o,    // Select in low nibble
    output data_t      col_o         // Active-low keys of selected row
);
    localparam int SEL_BITS = 4;

    data_t               key_rows_q [ROWS];  // Pressed keys per row
    logic [SEL_BITS-1:0] row_sel_q;          // CPU row select
    data_t               sel_row;            // Row picked by the select
    logic                row_valid;          // Select inside the matrix

    // Row select register
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            row_sel_q <= '0;
        end else if (row_we_i) begin
            row_sel_q <= cpu_wdata_i[SEL_BITS-1:0];  // Upper bits dropped
        end
    end

    // Key rows, cleared to no key pressed
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int r = 0; r < ROWS; r++) begin
                key_rows_q[r] <= '0;
            end
        end else if (key_we_i) begin
            for (int r = 0; r < ROWS; r++) begin
                // Targets past the last row fall through untouched
                if (key_row_i == r[$bits(host_addr_t)-1:0]) begin
                    key_rows_q[r] <= key_data_i;
                end
            end
        end
    end

    // Pick the selected row without indexing past the array
    always_comb begin
        sel_row   = '0;
        row_valid = 1'b0;
        for (int r = 0; r < ROWS; r++) begin
            if (row_sel_q == r[SEL_BITS-1:0]) begin
                sel_row   = key_rows_q[r];
                row_valid = 1'b1;
            end
        end
    end

    assign row_sel_o = {{(DATA_WIDTH-SEL_BITS){1'b0}}, row_sel_q};

    // Idle lines read high, as with pull-ups on a real matrix
    assign col_o = (kbd_en_i && row_valid) ? ~sel_row : '1;

endmodule : keyboard_matrix

//--- src/host_regs.sv
// ****************************************
// Host registers
// Host write port, config register and key row forwarding
// ****************************************

`timescale 1ns/1ps

module host_regs
    import common_pkg::*;
    import io_map_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,

    // Host write port
    input  logic       host_valid_i,
    output logic       host_ready_o,
    input  host_addr_t host_addr_i,
    input  data_t      host_wdata_i,

    // CPU config write
    input  logic       cfg_we_i,
    input  data_t      cpu_wdata_i,

    // Key row write to the matrix
    output logic       key_we_o,
    output host_addr_t key_row_o,
    output data_t      key_data_o,

    // Config value and decoded bits
    output data_t      cfg_o,        // CPU read source
    output logic       rom_we_en_o,
    output logic       kbd_en_o
);
    logic [CFG_BITS-1:0] cfg_q;
    logic                host_cfg_sel;  // Host targets config
    logic                host_fire;     // Accepted host write

    assign host_cfg_sel = (host_addr_i == HOST_CFG_ADDR);

    // CPU cannot stall, so the host backs off on a config collision
    assign host_ready_o = ~(cfg_we_i & host_cfg_sel);
    assign host_fire    = host_valid_i & host_ready_o;

    // Forward key rows; other targets are accepted and dropped
    assign key_we_o   = host_fire & (host_addr_i < KEY_ROWS);
    assign key_row_o  = host_addr_i;
    assign key_data_o = host_wdata_i;

    // Config register, CPU first
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cfg_q <= CFG_RESET;
        end else if (cfg_we_i) begin
            cfg_q <= cpu_wdata_i[CFG_BITS-1:0];
        end else if (host_fire && host_cfg_sel) begin
            cfg_q <= host_wdata_i[CFG_BITS-1:0];
        end
    end

    assign cfg_o       = {{(DATA_WIDTH-CFG_BITS){1'b0}}, cfg_q};  // Unused bits read 0
    assign rom_we_en_o = cfg_q[CFG_ROM_WE_BIT];
    assign kbd_en_o    = cfg_q[CFG_KBD_EN_BIT];

endmodule : host_regs

//--- src/cpu_data_mux.sv
// ****************************************
// CPU data mux
// Picks the FPGA source that drives the CPU data bus
// ****************************************

`timescale 1ns/1ps

module cpu_data_mux
    import common_pkg::*;
#(
    parameter int COUNT = 3  // Number of FPGA sources
) (
    // Sources and their one-hot enables
    input  data_t [COUNT-1:0] data_i,
    input  logic  [COUNT-1:0] oe_i,

    // To the CPU data bus
    output data_t             data_o,
    output logic              oe_o    // Any source enabled
);
    // SRAM drives the bus on its own through ram_oe_o
    localparam int IDX_BITS = (COUNT > 1) ? $clog2(COUNT) : 1;

    logic [IDX_BITS-1:0] sel_idx;  // Position of the set enable

    // One-hot to binary
    always_comb begin
        sel_idx = '0;
        for (int i = 0; i < COUNT; i++) begin
            if (oe_i[i]) begin
                sel_idx = i[IDX_BITS-1:0];
            end
        end
    end

    // Don't-care when nothing drives the bus
    assign data_o = (|oe_i) ? data_i[sel_idx] : 'x;
    assign oe_o   = |oe_i;

endmodule : cpu_data_mux

//--- src/pet_bus_top.sv
// ****************************************
// PET data bus subsystem
// Decoder, keyboard, host registers and read mux
// ****************************************

`timescale 1ns/1ps

module pet_bus_top
    import common_pkg::*;
    import io_map_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,

    // 6502 bus cycle
    input  logic       cpu_strobe_i,  // One clock per cycle
    input  addr_t      cpu_addr_i,
    input  logic       cpu_rw_i,      // 1 = read
    input  data_t      cpu_wdata_i,

    // Host write port
    input  logic       host_valid_i,
    output logic       host_ready_o,
    input  host_addr_t host_addr_i,
    input  data_t      host_wdata_i,

    // Read data from the FPGA
    output data_t      cpu_rdata_o,
    output logic       cpu_oe_o,

    // SRAM controls
    output logic       ram_oe_o,
    output logic       ram_we_o
);
    logic [SRC_COUNT-1:0] src_oe;    // One-hot read select
    data_t [SRC_COUNT-1:0] src_data; // Read sources in mux order
    logic                 row_we;
    logic                 cfg_we;
    logic                 rom_we_en;
    logic                 kbd_en;
    logic                 key_we;
    host_addr_t           key_row;
    data_t                key_data;
    data_t                row_sel;
    data_t                col;
    data_t                cfg;

    address_decoder u_decoder (
        .cpu_strobe_i (cpu_strobe_i),
        .cpu_rw_i     (cpu_rw_i),
        .cpu_addr_i   (cpu_addr_i),
        .rom_we_en_i  (rom_we_en),
        .src_oe_o     (src_oe),
        .row_we_o     (row_we),
        .cfg_we_o     (cfg_we),
        .ram_oe_o     (ram_oe_o),
        .ram_we_o     (ram_we_o)
    );

    keyboard_matrix #(
        .ROWS (KEY_ROWS)
    ) u_keyboard (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .row_we_i    (row_we),
        .cpu_wdata_i (cpu_wdata_i),
        .key_we_i    (key_we),
        .key_row_i   (key_row),
        .key_data_i  (key_data),
        .kbd_en_i    (kbd_en),
        .row_sel_o   (row_sel),
        .col_o       (col)
    );

    host_regs u_host_regs (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .host_valid_i (host_valid_i),
        .host_ready_o (host_ready_o),
        .host_addr_i  (host_addr_i),
        .host_wdata_i (host_wdata_i),
        .cfg_we_i     (cfg_we),
        .cpu_wdata_i  (cpu_wdata_i),
        .key_we_o     (key_we),
        .key_row_o    (key_row),
        .key_data_o   (key_data),
        .cfg_o        (cfg),
        .rom_we_en_o  (rom_we_en),
        .kbd_en_o     (kbd_en)
    );

    // Pack sources at their mux positions
    assign src_data[SRC_KBD_ROW] = row_sel;
    assign src_data[SRC_KBD_COL] = col;
    assign src_data[SRC_CFG]     = cfg;

    cpu_data_mux #(
        .COUNT (SRC_COUNT)
    ) u_data_mux (
        .data_i (src_data),
        .oe_i   (src_oe),
        .data_o (cpu_rdata_o),
        .oe_o   (cpu_oe_o)
    );

endmodule : pet_bus_top

//--- test/pet_bus_properties.sv
// ****************************************
// Bus properties
// Select exclusivity and strobe gating
// ****************************************

`timescale 1ns/1ps

module pet_bus_properties
    import io_map_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 cpu_strobe_i,
    input  logic [SRC_COUNT-1:0] oe_i,       // Mux enables
    input  logic                 cpu_oe_o,
    input  logic                 ram_oe_o,
    input  logic                 ram_we_o
);
    // At most one FPGA source on the bus
    a_oe_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(oe_i))
        else $error("mux enables not one-hot: %b", oe_i);

    // Controls only move inside a bus cycle
    a_ctrl_needs_strobe: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !cpu_strobe_i |-> !(cpu_oe_o || ram_oe_o || ram_we_o))
        else $error("bus control high without strobe");

    // SRAM and FPGA never drive together
    a_no_bus_fight: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(ram_oe_o && cpu_oe_o))
        else $error("ram_oe_o and cpu_oe_o both high");

endmodule : pet_bus_properties

// src_oe is the enable vector of the data mux inside the top level
bind pet_bus_top pet_bus_properties u_properties (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .cpu_strobe_i (cpu_strobe_i),
    .oe_i         (src_oe),
    .cpu_oe_o     (cpu_oe_o),
    .ram_oe_o     (ram_oe_o),
    .ram_we_o     (ram_we_o)
);

//--- test/tb_pet_bus.sv
// ****************************************
// PET bus testbench
// Random CPU and host traffic against a model
// ****************************************

`timescale 1ns/1ps

module tb_pet_bus
    import common_pkg::*;
    import io_map_pkg::*;
();
    localparam int TIMEOUT_CYCLES = 50;  // Longest host stall tolerated

    logic       clk = 1'b0;
    logic       rst_n;
    logic       cpu_strobe, cpu_rw, host_valid, host_ready;
    logic       cpu_oe, ram_oe, ram_we;
    addr_t      cpu_addr;
    data_t      cpu_wdata, host_wdata, cpu_rdata;
    host_addr_t host_addr;

    // Reference model state
    data_t               model_rows [KEY_ROWS];
    logic [3:0]          model_sel;
    logic [CFG_BITS-1:0] model_cfg;

    // Outputs captured mid-cycle
    data_t smp_rdata;
    logic  smp_oe, smp_ram_oe, smp_ram_we, smp_ready;

    always #10 clk = ~clk;  // 20 ns period

    pet_bus_top dut_i (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .cpu_strobe_i (cpu_strobe),
        .cpu_addr_i   (cpu_addr),
        .cpu_rw_i     (cpu_rw),
        .cpu_wdata_i  (cpu_wdata),
        .host_valid_i (host_valid),
        .host_ready_o (host_ready),
        .host_addr_i  (host_addr),
        .host_wdata_i (host_wdata),
        .cpu_rdata_o  (cpu_rdata),
        .cpu_oe_o     (cpu_oe),
        .ram_oe_o     (ram_oe),
        .ram_we_o     (ram_we)
    );

    task automatic check_value(input string name, input logic [15:0] actual,
                               input logic [15:0] expected);
        if (actual !== expected) begin
            $display("** Error: %s = 0x%0h, expected 0x%0h", name, actual, expected);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    function automatic addr_t io_addr(input io_ofs_t ofs);
        return {IO_BASE[ADDR_WIDTH-1:IO_OFS_BITS], ofs};  // Inside the I/O page
    endfunction

    // Active-low column of the selected row
    function automatic data_t expected_col();
        if (!model_cfg[CFG_KBD_EN_BIT] || int'(model_sel) >= KEY_ROWS) begin
            return 8'hFF;
        end
        return ~model_rows[model_sel];
    endfunction

    // One strobe clock; outputs are sampled on the falling edge
    task automatic bus_cycle(input addr_t addr, input logic rw, input data_t wdata);
        @(posedge clk);
        cpu_strobe <= 1'b1;
        cpu_addr   <= addr;
        cpu_rw     <= rw;
        cpu_wdata  <= wdata;
        @(negedge clk);
        smp_rdata  = cpu_rdata;
        smp_oe     = cpu_oe;
        smp_ram_oe = ram_oe;
        smp_ram_we = ram_we;
        @(posedge clk);
        cpu_strobe <= 1'b0;  // Registers took the write on this edge
    endtask

    task automatic read_io(input io_ofs_t ofs, input data_t expected);
        bus_cycle(io_addr(ofs), 1'b1, 8'h00);
        check_value("cpu_oe_o", smp_oe, 1'b1);
        check_value("ram_oe_o", smp_ram_oe, 1'b0);
        check_value("cpu_rdata_o", smp_rdata, expected);
    endtask

    task automatic write_io(input io_ofs_t ofs, input data_t data);
        bus_cycle(io_addr(ofs), 1'b0, data);
        check_value("ram_we_o", smp_ram_we, 1'b0);
        check_value("cpu_oe_o", smp_oe, 1'b0);
        if (ofs == KBD_ROW_OFS) model_sel = data[3:0];
        if (ofs == CFG_OFS) model_cfg = data[CFG_BITS-1:0];
    endtask

    // SRAM access outside the I/O page
    task automatic ram_access(input addr_t addr, input logic rw, input data_t data);
        logic exp_we;
        exp_we = !rw && ((addr < ROM_BASE) || model_cfg[CFG_ROM_WE_BIT]);
        bus_cycle(addr, rw, data);
        check_value("ram_oe_o", smp_ram_oe, rw);
        check_value("ram_we_o", smp_ram_we, exp_we);
        check_value("cpu_oe_o", smp_oe, 1'b0);
    endtask

    task automatic host_write(input host_addr_t addr, input data_t data);
        int waited;
        waited = 0;
        @(posedge clk);
        host_valid <= 1'b1;
        host_addr  <= addr;
        host_wdata <= data;
        @(negedge clk);
        while (!host_ready) begin
            waited++;
            if (waited >= TIMEOUT_CYCLES) begin
                $display("Timeout: host_ready_o stayed low on a host write");
                $display("Regression failed");
                $fatal(1);
            end
            @(negedge clk);
        end
        @(posedge clk);
        host_valid <= 1'b0;  // Accepted on this edge
        if (int'(addr) < KEY_ROWS) model_rows[addr] = data;
        else if (addr == HOST_CFG_ADDR) model_cfg = data[CFG_BITS-1:0];
    endtask

    initial begin
        addr_t   addr;
        io_ofs_t ofs;
        data_t   cpu_val, host_val;
        int      row;
        void'($urandom(61298));
        rst_n = 1'b0;
        cpu_strobe = 1'b0;
        cpu_rw = 1'b1;
        cpu_addr = '0;
        cpu_wdata = '0;
        host_valid = 1'b0;
        host_addr = '0;
        host_wdata = '0;
        for (int r = 0; r < KEY_ROWS; r++) model_rows[r] = '0;
        model_sel = '0;
        model_cfg = CFG_RESET;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        // Reset values
        @(negedge clk);
        check_value("host_ready_o", host_ready, 1'b1);
        read_io(CFG_OFS, 8'h02);
        read_io(KBD_COL_OFS, 8'hFF);

        // Host loads rows, CPU scans them
        for (int i = 0; i < 20; i++) begin
            host_write(host_addr_t'($urandom % KEY_ROWS), data_t'($urandom));
        end
        for (int i = 0; i < 40; i++) begin
            write_io(KBD_ROW_OFS, data_t'($urandom));  // Upper nibble is noise
            read_io(KBD_ROW_OFS, {4'h0, model_sel});
            read_io(KBD_COL_OFS, expected_col());
        end
        for (int r = 10; r < 16; r++) begin
            write_io(KBD_ROW_OFS, data_t'(r));  // Past the last row
            read_io(KBD_COL_OFS, 8'hFF);
        end

        // Unused I/O offsets touch nothing
        for (int i = 0; i < 20; i++) begin
            ofs = io_ofs_t'($urandom);
            if (ofs == KBD_ROW_OFS || ofs == KBD_COL_OFS || ofs == CFG_OFS) ofs = 8'h00;
            bus_cycle(io_addr(ofs), 1'b1, 8'h00);
            check_value("cpu_oe_o", smp_oe, 1'b0);
            check_value("ram_oe_o", smp_ram_oe, 1'b0);
            bus_cycle(io_addr(ofs), 1'b0, data_t'($urandom));
            check_value("ram_we_o", smp_ram_we, 1'b0);
            read_io(CFG_OFS, {6'h00, model_cfg});
            read_io(KBD_ROW_OFS, {4'h0, model_sel});
        end

        // SRAM space, ROM locked then open
        for (int phase = 0; phase < 2; phase++) begin
            write_io(CFG_OFS, {6'($urandom), 1'b1, phase[0]});
            for (int i = 0; i < 30; i++) begin
                addr = addr_t'($urandom);
                if (addr[ADDR_WIDTH-1:IO_OFS_BITS] == IO_BASE[ADDR_WIDTH-1:IO_OFS_BITS]) begin
                    addr[IO_OFS_BITS] = ~addr[IO_OFS_BITS];  // Step off the I/O page
                end
                ram_access(addr, 1'($urandom), data_t'($urandom));
            end
        end

        // Keyboard enable from both sides
        row = $urandom % KEY_ROWS;
        host_write(host_addr_t'(row), data_t'($urandom) | 8'h01);
        write_io(KBD_ROW_OFS, data_t'(row));
        write_io(CFG_OFS, 8'h00);
        read_io(KBD_COL_OFS, 8'hFF);
        write_io(CFG_OFS, 8'h02);
        read_io(KBD_COL_OFS, expected_col());
        host_write(HOST_CFG_ADDR, 8'h01);
        read_io(KBD_COL_OFS, 8'hFF);
        host_write(HOST_CFG_ADDR, 8'hFE);  // Upper bits masked off
        read_io(KBD_COL_OFS, expected_col());
        read_io(CFG_OFS, 8'h02);

        // CPU and host hit the config register together
        for (int i = 0; i < 4; i++) begin
            cpu_val  = data_t'($urandom);
            host_val = data_t'($urandom);
            @(posedge clk);
            cpu_strobe <= 1'b1;
            cpu_addr   <= io_addr(CFG_OFS);
            cpu_rw     <= 1'b0;
            cpu_wdata  <= cpu_val;
            host_valid <= 1'b1;
            host_addr  <= HOST_CFG_ADDR;
            host_wdata <= host_val;
            @(negedge clk);
            check_value("host_ready_o", host_ready, 1'b0);
            @(posedge clk);
            model_cfg = cpu_val[CFG_BITS-1:0];  // CPU wins first
            cpu_rw <= 1'b1;                     // Read back, host still waiting
            @(negedge clk);
            check_value("host_ready_o", host_ready, 1'b1);
            check_value("cpu_rdata_o", cpu_rdata, {6'h00, model_cfg});
            @(posedge clk);
            cpu_strobe <= 1'b0;
            host_valid <= 1'b0;
            model_cfg = host_val[CFG_BITS-1:0];
            read_io(CFG_OFS, {6'h00, model_cfg});
        end

        $display("Regression passed");
        $finish;
    end

endmodule : tb_pet_bus

//--- pet_bus.f
src/common_pkg.sv
src/io_map_pkg.sv
src/address_decoder.sv
src/keyboard_matrix.sv
src/host_regs.sv
src/cpu_data_mux.sv
src/pet_bus_top.sv
test/pet_bus_properties.sv
test/tb_pet_bus.sv

//--- run_sim.sh
#!/bin/sh
# Build the PET bus testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

MDIR=obj_dir
BIN=sim_pet_bus
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_pet_bus \
    --Mdir "$MDIR" -o "$BIN" \
    -f pet_bus.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$MDIR/$BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

grep -q "Regression passed" "$LOG"
if [ $? -ne 0 ]; then
    echo "Pass message not found in $LOG"
    exit 1
fi

echo "Simulation finished cleanly"
exit 0
